/* verilog/sdram_mux_settings.svh */
// Sizes and SDRAM base offsets of the slot multiplexer
// Included by the package, the RTL and the testbench
`ifndef SDRAM_MUX_SETTINGS_SVH
`define SDRAM_MUX_SETTINGS_SVH

// One bit per slot in the slot masks
`define SLOTS      4

// VRAM and SDRAM addresses count 16-bit units, ROM addresses 32-bit units
`define VRAM_AW    17
`define ROM_AW     20
`define SDRAM_AW   22

// Data widths
`define VRAM_DW    16
`define ROM_DW     32
`define SDRAM_DW   32

// Where each region starts in SDRAM
`define VRAM_BASE  22'h00_0000
`define GFX_BASE   22'h10_0000

`endif

/* verilog/sdram_mux_pkg.sv */
// Shared types of the SDRAM slot multiplexer
// Modules pull these in with a wildcard import in their header
`include "sdram_mux_settings.svh"

package sdram_mux_pkg;

    // SDRAM side
    typedef logic [`SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [`SDRAM_DW-1:0] sdram_word_t;

    // Slot payloads
    typedef logic [`VRAM_DW-1:0]  vram_word_t;
    typedef logic [`ROM_DW-1:0]   rom_word_t;

    // Slot bookkeeping
    typedef logic [`SLOTS-1:0]          slot_mask_t;
    typedef logic [$clog2(`SLOTS)-1:0]  slot_idx_t;

endpackage

/* verilog/slot_port.sv */
// Front end of one read slot of the SDRAM mux
// Holds the last fetched word with its address and asks the arbiter for a
// fetch whenever the client selects an address it does not hold
`include "sdram_mux_settings.svh"

module slot_port
    import sdram_mux_pkg::*;
#(
    parameter type payload_t = vram_word_t,
    // 16-bit payloads are VRAM slots, wider ones are ROM slots
    localparam int AW = ($bits(payload_t) == `VRAM_DW) ? `VRAM_AW : `ROM_AW
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          slot_cs,
    input  logic [AW-1:0] slot_addr,
    input  logic          fill,
    input  sdram_word_t   fill_data,
    output logic          slot_ok,
    output payload_t      slot_data,
    output logic          slot_need
);

    logic [AW-1:0] served_addr;
    logic          valid;
    logic          hit;

    // Held word matches what the client is asking for
    assign hit       = valid && (served_addr == slot_addr);
    assign slot_need = slot_cs && !hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= 1'b0;
            slot_ok <= 1'b0;
        end else begin
            if (fill) begin
                valid <= 1'b1;
            end
            // ok follows cs and the address one clock late
            slot_ok <= fill || (slot_cs && hit);
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            served_addr <= slot_addr;
            // VRAM slots keep the low half only
            slot_data   <= payload_t'(fill_data[$bits(payload_t)-1:0]);
        end
    end

endmodule

/* verilog/slot_arbiter.sv */
// Rotating-priority arbiter of the SDRAM slot mux
// Picks the next slot that needs data, maps its address into SDRAM and
// hands one registered grant to the sequencer per access
`include "sdram_mux_settings.svh"

module slot_arbiter
    import sdram_mux_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    input  slot_mask_t          slot_need,
    input  logic [`VRAM_AW-1:0] vram0_addr,
    input  logic [`VRAM_AW-1:0] vram1_addr,
    input  logic [`ROM_AW-1:0]  rom0_addr,
    input  logic [`ROM_AW-1:0]  rom1_addr,
    input  logic                busy,
    output logic                grant_valid,
    output slot_idx_t           grant_slot,
    output sdram_addr_t         grant_addr,
    output logic                refresh_en
);

    sdram_addr_t slot_sdram_addr [`SLOTS];
    slot_idx_t   ptr;
    slot_idx_t   pick;
    slot_idx_t   idx;
    logic        found;
    logic        hold;
    logic        seen_busy;
    logic        can_grant;

    // VRAM is word addressed, ROM words take two SDRAM locations
    assign slot_sdram_addr[0] = `VRAM_BASE + sdram_addr_t'(vram0_addr);
    assign slot_sdram_addr[1] = `VRAM_BASE + sdram_addr_t'(vram1_addr);
    assign slot_sdram_addr[2] = `GFX_BASE + sdram_addr_t'({rom0_addr, 1'b0});
    assign slot_sdram_addr[3] = `GFX_BASE + sdram_addr_t'({rom1_addr, 1'b0});

    // First needing slot at or after the pointer
    always_comb begin
        pick  = ptr;
        found = 1'b0;
        idx   = ptr;
        for (int i = 0; i < `SLOTS; i++) begin
            idx = slot_idx_t'((int'(ptr) + i) % `SLOTS);
            if (!found && slot_need[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    assign can_grant  = found && !hold && !busy && !downloading;
    assign refresh_en = !busy && !(|slot_need) && !downloading;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr         <= '0;
            grant_valid <= 1'b0;
            grant_slot  <= '0;
            hold        <= 1'b0;
            seen_busy   <= 1'b0;
        end else begin
            grant_valid <= 1'b0;
            if (can_grant) begin
                grant_valid <= 1'b1;
                grant_slot  <= pick;
                ptr         <= slot_idx_t'((int'(pick) + 1) % `SLOTS);
                hold        <= 1'b1;
                seen_busy   <= 1'b0;
            end else if (hold) begin
                // Release only once the sequencer went busy and came back
                if (busy) begin
                    seen_busy <= 1'b1;
                end else if (seen_busy) begin
                    hold <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_grant) begin
            grant_addr <= slot_sdram_addr[pick];
        end
    end

endmodule

/* verilog/sdram_sequencer.sv */
// Runs one read on the SDRAM controller per grant
// Holds sdram_req until ack, waits for data_rdy and routes the word
// back to the granted slot as a single-cycle fill
module sdram_sequencer
    import sdram_mux_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        grant_valid,
    input  slot_idx_t   grant_slot,
    input  sdram_addr_t grant_addr,
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_word_t data_read,
    output logic        busy,
    output slot_mask_t  fill_mask,
    output sdram_word_t fill_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_DATA
    } seq_state_t;

    seq_state_t state;
    slot_idx_t  slot_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_IDLE;
            slot_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant_valid) begin
                        slot_q <= grant_slot;
                        state  <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // Controller took the request
                    if (sdram_ack) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (data_rdy) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address is held for the whole access
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && grant_valid) begin
            sdram_addr <= grant_addr;
        end
    end

    assign sdram_req = (state == ST_REQ);
    assign busy      = (state != ST_IDLE);

    // Fill goes out in the data_rdy cycle, so ok rises on the next clock
    assign fill_mask = (state == ST_DATA && data_rdy) ? slot_mask_t'(1) << slot_q : '0;
    assign fill_data = data_read;

endmodule

/* verilog/sdram_mux.sv */
// Top level of the SDRAM slot multiplexer
// Two VRAM readers and two GFX ROM readers share one SDRAM controller
// through per-slot front ends, a rotating arbiter and a read sequencer
`include "sdram_mux_settings.svh"

module sdram_mux
    import sdram_mux_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    // Tile-map VRAM readers
    input  logic                vram0_cs,
    input  logic [`VRAM_AW-1:0] vram0_addr,
    output logic                vram0_ok,
    output vram_word_t          vram0_data,
    input  logic                vram1_cs,
    input  logic [`VRAM_AW-1:0] vram1_addr,
    output logic                vram1_ok,
    output vram_word_t          vram1_data,
    // GFX ROM readers
    input  logic                rom0_cs,
    input  logic [`ROM_AW-1:0]  rom0_addr,
    output logic                rom0_ok,
    output rom_word_t           rom0_data,
    input  logic                rom1_cs,
    input  logic [`ROM_AW-1:0]  rom1_addr,
    output logic                rom1_ok,
    output rom_word_t           rom1_data,
    // SDRAM controller
    output logic                sdram_req,
    output sdram_addr_t         sdram_addr,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  sdram_word_t         data_read,
    output logic                refresh_en
);

    slot_mask_t  slot_need;
    slot_mask_t  fill_mask;
    sdram_word_t fill_data;
    logic        grant_valid;
    slot_idx_t   grant_slot;
    sdram_addr_t grant_addr;
    logic        busy;

    // Slot 0
    slot_port #(.payload_t(vram_word_t)) u_vram0 (
        .clk       ( clk          ),
        .arst_n    ( arst_n       ),
        .slot_cs   ( vram0_cs     ),
        .slot_addr ( vram0_addr   ),
        .fill      ( fill_mask[0] ),
        .fill_data ( fill_data    ),
        .slot_ok   ( vram0_ok     ),
        .slot_data ( vram0_data   ),
        .slot_need ( slot_need[0] )
    );

    // Slot 1
    slot_port #(.payload_t(vram_word_t)) u_vram1 (
        .clk       ( clk          ),
        .arst_n    ( arst_n       ),
        .slot_cs   ( vram1_cs     ),
        .slot_addr ( vram1_addr   ),
        .fill      ( fill_mask[1] ),
        .fill_data ( fill_data    ),
        .slot_ok   ( vram1_ok     ),
        .slot_data ( vram1_data   ),
        .slot_need ( slot_need[1] )
    );

    // Slot 2
    slot_port #(.payload_t(rom_word_t)) u_rom0 (
        .clk       ( clk          ),
        .arst_n    ( arst_n       ),
        .slot_cs   ( rom0_cs      ),
        .slot_addr ( rom0_addr    ),
        .fill      ( fill_mask[2] ),
        .fill_data ( fill_data    ),
        .slot_ok   ( rom0_ok      ),
        .slot_data ( rom0_data    ),
        .slot_need ( slot_need[2] )
    );

    // Slot 3
    slot_port #(.payload_t(rom_word_t)) u_rom1 (
        .clk       ( clk          ),
        .arst_n    ( arst_n       ),
        .slot_cs   ( rom1_cs      ),
        .slot_addr ( rom1_addr    ),
        .fill      ( fill_mask[3] ),
        .fill_data ( fill_data    ),
        .slot_ok   ( rom1_ok      ),
        .slot_data ( rom1_data    ),
        .slot_need ( slot_need[3] )
    );

    slot_arbiter u_arbiter (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .slot_need   ( slot_need   ),
        .vram0_addr  ( vram0_addr  ),
        .vram1_addr  ( vram1_addr  ),
        .rom0_addr   ( rom0_addr   ),
        .rom1_addr   ( rom1_addr   ),
        .busy        ( busy        ),
        .grant_valid ( grant_valid ),
        .grant_slot  ( grant_slot  ),
        .grant_addr  ( grant_addr  ),
        .refresh_en  ( refresh_en  )
    );

    sdram_sequencer u_sequencer (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .grant_valid ( grant_valid ),
        .grant_slot  ( grant_slot  ),
        .grant_addr  ( grant_addr  ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .busy        ( busy        ),
        .fill_mask   ( fill_mask   ),
        .fill_data   ( fill_data   )
    );

endmodule

/* verif/sdram_model.sv */
// Behavioral SDRAM controller for the slot mux testbench
// Acks each request and returns an address-derived word after delays that
// the testbench sets through ack_delay and data_delay
module sdram_model
    import sdram_mux_pkg::*;
(
    input  logic        clk,
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    input  int          ack_delay,
    input  int          data_delay,
    output logic        sdram_ack,
    output logic        data_rdy,
    output sdram_word_t data_read
);
    timeunit 1ns;
    timeprecision 1ps;

    sdram_addr_t addr;

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #1;
            if (sdram_req) begin
                addr = sdram_addr;
                repeat (ack_delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                sdram_ack = 1'b1;
                @(posedge clk);
                #1;
                sdram_ack = 1'b0;
                repeat (data_delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                // Low half from the address, high half from the next one
                data_read = {16'(addr + 1) ^ 16'hA5C3, addr[15:0] ^ 16'hA5C3};
                data_rdy  = 1'b1;
                @(posedge clk);
                #1;
                data_rdy  = 1'b0;
            end
        end
    end

endmodule

/* verif/tb_sdram_mux.sv */
// Testbench top of the SDRAM slot mux
// Runs a table of slot requests against a behavioral SDRAM controller and
// checks returned data, SDRAM access order, ok hold behavior and idle outputs
`include "sdram_mux_settings.svh"

module tb_sdram_mux
    import sdram_mux_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS = 8;
    localparam int NROWS  = 7;

    typedef enum logic [1:0] {
        M_PLAIN,
        M_HOLD,
        M_CHANGE,    // lowest slot in the mask moves to a new address
        M_DOWNLOAD
    } mode_t;

    typedef struct packed {
        logic [3:0]  mask;
        mode_t       mode;
        logic [19:0] a0;
        logic [19:0] a1;
        logic [19:0] a2;
        logic [19:0] a3;
    } row_t;

    // Slot mask, mode, then vram0, vram1, rom0 and rom1 addresses
    localparam row_t ROWS [NROWS] = '{
        '{4'b0001, M_PLAIN,    20'h1_2345, 20'h0_0000, 20'h0_0000, 20'h0_0000},
        '{4'b0100, M_PLAIN,    20'h0_0000, 20'h0_0000, 20'hA_BCDE, 20'h0_0000},
        '{4'b1111, M_PLAIN,    20'h0_0010, 20'h1_FFFF, 20'h0_0040, 20'hF_FFFF},
        '{4'b0010, M_HOLD,     20'h0_0000, 20'h0_4321, 20'h0_0000, 20'h0_0000},
        '{4'b1000, M_CHANGE,   20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h5_5555},
        '{4'b1011, M_DOWNLOAD, 20'h0_7777, 20'h0_0888, 20'h0_0000, 20'h3_3333},
        '{4'b1111, M_HOLD,     20'h1_0001, 20'h0_0002, 20'h7_0003, 20'h8_0004}
    };

    logic        clk;
    logic        arst_n;
    logic        downloading;
    logic [3:0]  cs;
    logic [19:0] addr [4];
    wire  [3:0]  ok;
    vram_word_t  vram0_data;
    vram_word_t  vram1_data;
    rom_word_t   rom0_data;
    rom_word_t   rom1_data;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_ack;
    logic        data_rdy;
    sdram_word_t data_read;
    logic        refresh_en;
    int          ack_delay;
    int          data_delay;
    int          ptr;
    logic        req_prev;
    sdram_addr_t exp_q [$];
    sdram_addr_t seen_q [$];

    sdram_mux u_dut (
        .clk(clk), .arst_n(arst_n), .downloading(downloading),
        .vram0_cs(cs[0]), .vram0_addr(addr[0][16:0]), .vram0_ok(ok[0]), .vram0_data(vram0_data),
        .vram1_cs(cs[1]), .vram1_addr(addr[1][16:0]), .vram1_ok(ok[1]), .vram1_data(vram1_data),
        .rom0_cs(cs[2]), .rom0_addr(addr[2]), .rom0_ok(ok[2]), .rom0_data(rom0_data),
        .rom1_cs(cs[3]), .rom1_addr(addr[3]), .rom1_ok(ok[3]), .rom1_data(rom1_data),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read), .refresh_en(refresh_en)
    );

    sdram_model u_sdram (
        .clk(clk), .sdram_req(sdram_req), .sdram_addr(sdram_addr),
        .ack_delay(ack_delay), .data_delay(data_delay),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Record the address of every new SDRAM request
    always @(negedge clk) begin
        if (sdram_req && !req_prev) begin
            seen_q.push_back(sdram_addr);
        end
        req_prev = sdram_req;
    end

    initial begin
        #(NROWS * 4 * 20 * CLK_NS + 10 * CLK_NS);
        $display("run timed out waiting for the DUT");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    function automatic sdram_addr_t map_addr(int slot, logic [19:0] a);
        if (slot < 2) begin
            return `VRAM_BASE + sdram_addr_t'(a[16:0]);
        end
        return `GFX_BASE + sdram_addr_t'(a) * 22'd2;
    endfunction

    function automatic logic [31:0] expect_data(int slot, logic [19:0] a);
        sdram_addr_t sa;
        logic [31:0] w;
        sa = map_addr(slot, a);
        w  = {16'(sa + 1) ^ 16'hA5C3, sa[15:0] ^ 16'hA5C3};
        return (slot < 2) ? {16'h0, w[15:0]} : w;
    endfunction

    function automatic logic [31:0] data_of(int slot);
        case (slot)
            0:       return {16'h0, vram0_data};
            1:       return {16'h0, vram1_data};
            2:       return rom0_data;
            default: return rom1_data;
        endcase
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ok(logic [3:0] mask);
        while ((ok & mask) != mask) begin
            next_cycle();
        end
    endtask

    task automatic check_slots(logic [3:0] mask);
        for (int n = 0; n < 4; n++) begin
            if (mask[n]) begin
                check($sformatf("slot%0d_data", n), expect_data(n, addr[n]), data_of(n));
            end
        end
    endtask

    // Rotating order from the current pointer for slots that request together
    task automatic expect_grants(logic [3:0] mask);
        int s;
        int last;
        last = -1;
        for (int i = 0; i < 4; i++) begin
            s = (ptr + i) % 4;
            if (mask[s]) begin
                exp_q.push_back(map_addr(s, addr[s]));
                last = s;
            end
        end
        if (last >= 0) begin
            ptr = (last + 1) % 4;
        end
    endtask

    task automatic check_idle();
        check("sdram_req", 32'd0, 32'(sdram_req));
        check("ok", 32'd0, 32'(ok));
        check("refresh_en", 32'd1, 32'(refresh_en));
    endtask

    task automatic run_row(row_t r);
        int c;
        ack_delay  = 1 + int'($urandom % 4);
        data_delay = 2 + int'($urandom % 4);
        addr[0] = r.a0;
        addr[1] = r.a1;
        addr[2] = r.a2;
        addr[3] = r.a3;
        cs = r.mask;
        downloading = (r.mode == M_DOWNLOAD);
        expect_grants(r.mask);
        if (r.mode == M_DOWNLOAD) begin
            repeat (10) begin
                next_cycle();
                check("sdram_req", 32'd0, 32'(sdram_req));
                check("refresh_en", 32'd0, 32'(refresh_en));
            end
            downloading = 1'b0;
        end
        wait_ok(r.mask);
        check_slots(r.mask);
        if (r.mode == M_HOLD) begin
            repeat (8) begin
                next_cycle();
                check("ok", 32'(r.mask), 32'(ok & r.mask));
                check("sdram_req", 32'd0, 32'(sdram_req));
                check_slots(r.mask);
            end
        end
        if (r.mode == M_CHANGE) begin
            c = 0;
            for (int n = 3; n >= 0; n--) begin
                if (r.mask[n]) begin
                    c = n;
                end
            end
            addr[c] = addr[c] + 20'd3;
            expect_grants(4'(1 << c));
            next_cycle();
            check($sformatf("slot%0d_ok", c), 32'd0, 32'(ok[c]));
            wait_ok(r.mask);
            check_slots(r.mask);
        end
        cs = 4'b0000;
        next_cycle();
        next_cycle();
        check_idle();
        check("access count", 32'(exp_q.size()), 32'(seen_q.size()));
        while (exp_q.size() > 0) begin
            check("sdram_addr", 32'(exp_q.pop_front()), 32'(seen_q.pop_front()));
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        downloading = 1'b0;
        cs          = 4'b0000;
        ack_delay   = 1;
        data_delay  = 2;
        ptr         = 0;
        req_prev    = 1'b0;
        foreach (addr[i]) begin
            addr[i] = '0;
        end
        void'($urandom(32'h2998_1cd6));
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_idle();
        for (int r = 0; r < NROWS; r++) begin
            run_row(ROWS[r]);
        end
        $display("test passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+verilog
verilog/sdram_mux_pkg.sv
verilog/slot_port.sv
verilog/slot_arbiter.sv
verilog/sdram_sequencer.sv
verilog/sdram_mux.sv
verif/sdram_model.sv
verif/tb_sdram_mux.sv

/* run.sh */
#!/bin/sh
# Compile and run the SDRAM mux testbench with Verilator
# The result comes from the simulation log, not from the exit code
rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_sdram_mux \
    --Mdir obj_dir -o tb_sdram_mux > build.log 2>&1 &&
    ./obj_dir/tb_sdram_mux > sim.log 2>&1
cat build.log sim.log 2> /dev/null
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
